/* verilog/angle_pkg.sv */
// Angle to PWM shared definitions
// Widths, sequencer states and bundled buses for the motion sequencer

`default_nettype none

package angle_pkg;

    // Position on the 4096 count encoder circle, also used for distances
    typedef logic [11:0] angle_t;

    // PWM high time out of 255
    typedef logic [7:0] duty_t;

    // Index into the acceleration profile
    typedef logic [3:0] step_t;

    // Acknowledgement count per profile step
    typedef logic [11:0] pace_t;  // Holds delay_target * 16

    localparam int PROFILE_STEPS = 16;

    // Profile table, entry 0 in the low byte
    typedef duty_t [PROFILE_STEPS-1:0] profile_t;

    // Sequencer states
    typedef enum logic [2:0] {
        IDLE     = 3'd0,  // Waiting for a request
        CALC     = 3'd1,  // Distance and direction being worked out
        ACCEL    = 3'd2,  // Walking up the profile
        CRUISE   = 3'd3,  // Fixed power
        DECEL    = 3'd4,  // Walking back down the profile
        SHUTDOWN = 3'd5   // Zero ratio, waiting for the PWM to take it
    } motion_state_e;

    // Configuration, held stable for the length of a move
    typedef struct packed {
        logic [7:0] delay_target;    // Acks per step, in units of 16
        duty_t      profile_offset;  // Added to every profile entry
        duty_t      cruise_power;    // Ratio during cruise
    } motion_cfg_t;

    // Command to the PWM block
    typedef struct packed {
        duty_t ratio;      // High time out of 255
        logic  direction;  // 1 turns in the positive direction
        logic  update;     // Level, high while a move is running
    } pwm_cmd_t;

endpackage

`default_nettype wire

/* verilog/angle_delta.sv */
// Shortest path calculation
// Picks the turning direction and distance from encoder angle to target

`timescale 1ns/1ps
`default_nettype none

module angle_delta
    import angle_pkg::*;
(
    input  wire          clock,
    input  wire          reset_n,
    input  wire          calc_en,        // Request from the sequencer
    input  wire angle_t  target_angle,
    input  wire angle_t  current_angle,  // Encoder reading
    output angle_t       delta,          // Shortest distance
    output logic         dir_shortest,   // 1 for positive direction
    output logic         delta_valid     // calc_en one cycle later
);

    localparam angle_t HALF_TURN = angle_t'(2048);

    angle_t diff;     // Forward distance, wraps modulo 4096
    logic   fwd_ok;   // Forward path no longer than half a turn

    assign diff   = target_angle - current_angle;
    assign fwd_ok = (diff <= HALF_TURN);

    // Results refreshed every clock
    always_ff @(posedge clock) begin
        dir_shortest <= fwd_ok;
        if (fwd_ok) begin
            delta <= diff;
        end else begin
            // Going backwards, 4096 - diff
            delta <= angle_t'(0) - diff;
        end
    end

    // Valid flag follows the enable
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            delta_valid <= 1'b0;
        end else begin
            delta_valid <= calc_en;
        end
    end

endmodule

`default_nettype wire

/* verilog/step_pacer.sv */
// Profile step pacing
// Cleans the PWM acknowledgement into a rise pulse and counts
// acknowledgements against the programmed delay to time each step

`timescale 1ns/1ps
`default_nettype none

module step_pacer
    import angle_pkg::*;
(
    input  wire        clock,
    input  wire        reset_n,
    input  wire        pwm_done,      // PWM took a ratio
    input  wire        pace_en,       // Motor running
    input  wire [7:0]  delay_target,  // Acks per step, in units of 16
    output logic       step_tick,     // Advance the profile
    output logic       done_edge      // One pulse per acknowledgement
);

    logic  done_q;       // Previous pwm_done
    pace_t pace_cnt;     // Acks counted on this step
    pace_t pace_target;
    logic  cnt_hit;

    assign pace_target = {delay_target, 4'b0000};  // Times 16
    assign cnt_hit     = (pace_cnt == pace_target);

    // A level held over from the last ratio is not an acknowledgement
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            done_q    <= 1'b0;
            done_edge <= 1'b0;
        end else begin
            done_q    <= pwm_done;
            done_edge <= pwm_done & ~done_q;  // Rise only
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            pace_cnt <= '0;
        end else if (!pace_en) begin
            pace_cnt <= '0;  // Fresh count on every move
        end else if (done_edge) begin
            if (cnt_hit) begin
                pace_cnt <= '0;  // Step taken, start over
            end else begin
                pace_cnt <= pace_cnt + pace_t'(1);
            end
        end
    end

    // Zero delay makes every acknowledgement a step
    assign step_tick = pace_en & done_edge & cnt_hit;

endmodule

`default_nettype wire

/* verilog/motion_fsm.sv */
// Motion sequencer state machine
// Runs one move through calculate, accelerate, cruise, decelerate and
// shutdown, and owns the profile step, direction and update level

`timescale 1ns/1ps
`default_nettype none

module motion_fsm
    import angle_pkg::*;
#(
    parameter int unsigned TARGET_TOLERANCE = 5,   // Close enough to stop
    parameter int unsigned CRUISE_EXIT      = 10   // Distance to start braking
) (
    input  wire            clock,
    input  wire            reset_n,
    input  wire            angle_update,   // Move request strobe
    input  wire            abort_angle,    // Abort level
    input  wire angle_t    delta,          // Remaining distance
    input  wire            dir_shortest,
    input  wire            delta_valid,
    input  wire            step_tick,
    input  wire            done_edge,
    output logic           calc_en,
    output logic           pace_en,
    output motion_state_e  state,
    output step_t          step,           // Current profile entry
    output logic           direction,
    output logic           update,
    output logic           angle_done      // One cycle at end of move
);

    localparam angle_t TOL_LIMIT  = angle_t'(TARGET_TOLERANCE);
    localparam angle_t EXIT_LIMIT = angle_t'(CRUISE_EXIT);
    localparam step_t  LAST_STEP  = step_t'(PROFILE_STEPS - 1);

    motion_state_e next_state;
    logic          calc_go;    // Far enough away, start the move

    // Abort wins over the decision
    assign calc_go = (state == CALC) && !abort_angle && delta_valid &&
                     (delta > TOL_LIMIT);

    assign calc_en = (state == CALC);
    assign pace_en = (state == ACCEL) || (state == CRUISE) || (state == DECEL);

    always_comb begin
        next_state = state;  // Hold unless told otherwise
        case (state)
            IDLE: begin
                if (angle_update) begin
                    next_state = CALC;
                end
            end
            CALC: begin
                if (abort_angle) begin
                    next_state = IDLE;
                end else if (delta_valid) begin
                    // Already there, nothing to do
                    next_state = calc_go ? ACCEL : IDLE;
                end
            end
            ACCEL: begin
                if (abort_angle) begin
                    next_state = DECEL;  // Brake from where we are
                end else if (step_tick && (step == LAST_STEP)) begin
                    next_state = CRUISE;
                end
            end
            CRUISE: begin
                if (abort_angle || (delta < EXIT_LIMIT)) begin
                    next_state = DECEL;
                end
            end
            DECEL: begin
                if (delta < TOL_LIMIT) begin
                    next_state = SHUTDOWN;
                end
            end
            SHUTDOWN: begin
                // PWM acknowledged, motor off
                if (done_edge) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state      <= IDLE;
            step       <= '0;
            direction  <= 1'b0;
            update     <= 1'b0;
            angle_done <= 1'b0;
        end else begin
            state      <= next_state;
            angle_done <= (state == SHUTDOWN) && (next_state == IDLE);

            // Update level spans the whole move
            if (next_state == IDLE) begin
                update <= 1'b0;
            end else if (calc_go) begin
                update <= 1'b1;
            end

            if (calc_go) begin
                direction <= dir_shortest;  // Latched for the move
            end

            case (state)
                IDLE, CALC: begin
                    step <= '0;  // Every move starts at the bottom
                end
                ACCEL: begin
                    // Top step is held into cruise
                    if (step_tick && !abort_angle && (step != LAST_STEP)) begin
                        step <= step + step_t'(1);
                    end
                end
                DECEL: begin
                    if (step_tick && (step != '0)) begin
                        step <= step - step_t'(1);  // Saturates at 0
                    end
                end
                default: begin
                    step <= step;  // Cruise and shutdown keep the step
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/duty_select.sv */
// PWM ratio selection
// Looks up the profile step, adds the offset and picks the ratio
// for the current state, registered

`timescale 1ns/1ps
`default_nettype none

module duty_select
    import angle_pkg::*;
(
    input  wire                 clock,
    input  wire                 reset_n,
    input  wire motion_state_e  state,
    input  wire step_t          step,
    input  wire profile_t       pwm_profile,  // Entry 0 in the low byte
    input  wire motion_cfg_t    cfg,
    output duty_t               ratio         // High time out of 255
);

    duty_t profile_entry;
    duty_t profile_duty;  // Entry plus offset
    duty_t ratio_next;

    assign profile_entry = pwm_profile[step];

    // Offset wraps past 255 by design
    assign profile_duty = profile_entry + cfg.profile_offset;

    always_comb begin
        case (state)
            ACCEL, DECEL: begin
                ratio_next = profile_duty;
            end
            CRUISE: begin
                ratio_next = cfg.cruise_power;
            end
            default: begin
                // Idle, calculation and shutdown keep the motor off
                ratio_next = '0;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            ratio <= '0;
        end else begin
            ratio <= ratio_next;  // One cycle behind state and step
        end
    end

endmodule

`default_nettype wire

/* verilog/angle_to_pwm.sv */
// Angle to PWM motion sequencer top
// Shortest path, step pacing, sequencing FSM and ratio select,
// packed into a single command to the PWM

`timescale 1ns/1ps
`default_nettype none

module angle_to_pwm
    import angle_pkg::*;
#(
    parameter int unsigned TARGET_TOLERANCE = 5,
    parameter int unsigned CRUISE_EXIT      = 10
) (
    input  wire               clock,
    input  wire               reset_n,
    input  wire angle_t       target_angle,   // Where the wheel must go
    input  wire angle_t       current_angle,  // Encoder reading
    input  wire               angle_update,   // Start a move
    input  wire               abort_angle,    // Stop the move
    input  wire               pwm_done,       // PWM took the last ratio
    input  wire motion_cfg_t  cfg,
    input  wire profile_t     pwm_profile,
    output pwm_cmd_t          pwm_cmd,
    output logic              angle_done
);

    angle_t        delta;
    logic          dir_shortest;
    logic          delta_valid;
    logic          calc_en;
    logic          pace_en;
    logic          step_tick;
    logic          done_edge;
    motion_state_e state;
    step_t         step;
    logic          direction;
    logic          update;
    duty_t         ratio;

    angle_delta u_angle_delta (
        .clock         (clock),
        .reset_n       (reset_n),
        .calc_en       (calc_en),
        .target_angle  (target_angle),
        .current_angle (current_angle),
        .delta         (delta),
        .dir_shortest  (dir_shortest),
        .delta_valid   (delta_valid)
    );

    step_pacer u_step_pacer (
        .clock        (clock),
        .reset_n      (reset_n),
        .pwm_done     (pwm_done),
        .pace_en      (pace_en),
        .delay_target (cfg.delay_target),
        .step_tick    (step_tick),
        .done_edge    (done_edge)
    );

    motion_fsm #(
        .TARGET_TOLERANCE (TARGET_TOLERANCE),
        .CRUISE_EXIT      (CRUISE_EXIT)
    ) u_motion_fsm (
        .clock        (clock),
        .reset_n      (reset_n),
        .angle_update (angle_update),
        .abort_angle  (abort_angle),
        .delta        (delta),
        .dir_shortest (dir_shortest),
        .delta_valid  (delta_valid),
        .step_tick    (step_tick),
        .done_edge    (done_edge),
        .calc_en      (calc_en),
        .pace_en      (pace_en),
        .state        (state),
        .step         (step),
        .direction    (direction),
        .update       (update),
        .angle_done   (angle_done)
    );

    duty_select u_duty_select (
        .clock       (clock),
        .reset_n     (reset_n),
        .state       (state),
        .step        (step),
        .pwm_profile (pwm_profile),
        .cfg         (cfg),
        .ratio       (ratio)
    );

    // Command bundle to the PWM
    assign pwm_cmd = '{ratio: ratio, direction: direction, update: update};

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
// Testbench clock and reset
// 10 ns clock, active low reset held for 3 cycles

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic reset_n
);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        reset_n = 1'b0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;  // Released on a falling edge
    end

endmodule

`default_nettype wire

/* test/pwm_responder.sv */
// PWM and encoder model
// Acknowledges every 4 cycles and steps the encoder while the ratio is nonzero

`timescale 1ns/1ps
`default_nettype none

module pwm_responder
    import angle_pkg::*;
(
    input  wire          clock,
    input  wire          reset_n,
    input  wire duty_t   ratio,
    input  wire          direction,      // 1 counts up
    input  wire          load_en,        // Place the encoder by hand
    input  wire angle_t  load_angle,
    output logic         pwm_done,
    output angle_t       current_angle
);

    logic [1:0] phase;  // Position in the 4 cycle PWM period

    // Outputs change on the falling edge like the rest of the stimulus
    always_ff @(negedge clock) begin
        if (!reset_n) begin
            phase         <= 2'd0;
            pwm_done      <= 1'b0;
            current_angle <= '0;
        end else begin
            phase    <= phase + 2'd1;
            pwm_done <= (phase == 2'd3);  // One cycle high per period
            if (load_en) begin
                current_angle <= load_angle;
            end else if ((phase == 2'd3) && (ratio != '0)) begin
                // Wraps modulo 4096 through the 12 bit width
                current_angle <= direction ? current_angle + angle_t'(1)
                                           : current_angle - angle_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

/* test/tb_angle_to_pwm.sv */
// Angle to PWM sequencer testbench
// Directed moves against a PWM model, checks ratio order, direction and done

`timescale 1ns/1ps
`default_nettype none

module tb_angle_to_pwm
    import angle_pkg::*;
;

    logic        clock, reset_n;
    angle_t      target_angle, current_angle, load_angle;
    logic        angle_update, abort_angle, pwm_done, load_en, angle_done;
    motion_cfg_t cfg;
    profile_t    pwm_profile;
    pwm_cmd_t    pwm_cmd;

    int          errors = 0;
    int          tests_run = 0;
    duty_t       duties[PROFILE_STEPS];  // Profile entry plus offset, mod 256
    duty_t       ratio_log[$];           // Nonzero ratios in order of appearance
    int          done_count;

    tb_clock_gen u_clock_gen (.clock(clock), .reset_n(reset_n));

    pwm_responder u_pwm_responder (
        .clock(clock), .reset_n(reset_n), .ratio(pwm_cmd.ratio),
        .direction(pwm_cmd.direction), .load_en(load_en), .load_angle(load_angle),
        .pwm_done(pwm_done), .current_angle(current_angle)
    );

    angle_to_pwm u_angle_to_pwm (
        .clock(clock), .reset_n(reset_n), .target_angle(target_angle),
        .current_angle(current_angle), .angle_update(angle_update),
        .abort_angle(abort_angle), .pwm_done(pwm_done), .cfg(cfg),
        .pwm_profile(pwm_profile), .pwm_cmd(pwm_cmd), .angle_done(angle_done)
    );

    // Safety net over the whole run
    initial begin
        repeat (200000) @(posedge clock);
        $display("simulation ran too long, stopped by the watchdog");
        $display("*** FAILED ***");
        $finish;
    end

    task automatic expect_eq(input string name, input string what, input int exp, input int act);
        assert (exp == act) else begin
            $display("mismatch %s %s: expected %0d actual %0d", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        $display("test %s: %s", name, (errors == errors_before) ? "ok" : "failed");
    endtask

    function automatic bit in_profile(input duty_t value);
        foreach (duties[i]) begin
            if (duties[i] == value) return 1'b1;
        end
        return 1'b0;
    endfunction

    // Place the encoder, then strobe a request for the target
    task automatic request_move(input angle_t from, input angle_t to);
        @(negedge clock);
        load_angle = from;
        load_en    = 1'b1;
        repeat (2) @(negedge clock);  // Responder sees a settled load
        load_en      = 1'b0;
        target_angle = to;
        angle_update = 1'b1;
        @(negedge clock);
        angle_update = 1'b0;
    endtask

    // Logs ratio changes until angle_done plus a few cycles; optional abort
    task automatic watch_move(input string name, input int abort_after, input int max_cycles);
        duty_t last;
        int    tail;
        int    update_gaps;  // Cycles with a ratio but no update level
        bit    finished;
        ratio_log.delete();
        done_count  = 0;
        last        = '0;
        tail        = -1;
        update_gaps = 0;
        finished    = 1'b0;
        for (int n = 0; n < max_cycles; n++) begin
            @(negedge clock);
            if ((pwm_cmd.ratio != '0) && !pwm_cmd.update) update_gaps++;
            if ((pwm_cmd.ratio != last) && (pwm_cmd.ratio != '0)) begin
                ratio_log.push_back(pwm_cmd.ratio);
                // Abort just after a step change and well before the next tick
                if ((abort_after > 0) && (ratio_log.size() == abort_after)) abort_angle = 1'b1;
            end
            last = pwm_cmd.ratio;
            if (angle_done) done_count++;
            if (tail == 0) begin
                finished = 1'b1;
                break;
            end
            if (tail > 0) tail--;
            if ((done_count > 0) && (tail < 0)) tail = 8;  // Catch a second pulse
        end
        assert (finished) else begin
            $display("test %s: timed out waiting for angle_done", name);
            errors++;
        end
        expect_eq(name, "cycles with ratio but no update", 0, update_gaps);
        expect_eq(name, "update after move", 0, pwm_cmd.update);
    endtask

    // Short request must not start the motor
    task automatic small_move_check();
        int e0;
        e0 = errors;
        expect_eq("small_move", "reset ratio", 0, pwm_cmd.ratio);
        expect_eq("small_move", "reset update", 0, pwm_cmd.update);
        expect_eq("small_move", "reset angle_done", 0, angle_done);
        request_move(12'd300, 12'd303);
        for (int n = 0; n < 20; n++) begin
            @(negedge clock);
            expect_eq("small_move", "update", 0, pwm_cmd.update);
            expect_eq("small_move", "angle_done", 0, angle_done);
        end
        expect_eq("small_move", "state", int'(IDLE), int'(u_angle_to_pwm.state));
        finish_test("small_move", e0);
    endtask

    task automatic forward_move_check();
        int e0;
        e0 = errors;
        request_move(12'd1000, 12'd1200);
        watch_move("forward_move", 0, 6000);
        expect_eq("forward_move", "direction", 1, pwm_cmd.direction);
        expect_eq("forward_move", "angle_done pulses", 1, done_count);
        expect_eq("forward_move", "final ratio", 0, pwm_cmd.ratio);
        assert (ratio_log.size() >= 18) else begin
            $display("test forward_move: only %0d ratios seen, full profile missing",
                     ratio_log.size());
            errors++;
        end
        if (ratio_log.size() >= 18) begin
            for (int i = 0; i < PROFILE_STEPS; i++) begin
                expect_eq("forward_move", "accel ratio", duties[i], ratio_log[i]);
            end
            expect_eq("forward_move", "cruise ratio", cfg.cruise_power, ratio_log[16]);
            // Deceleration walks back down from step 15
            for (int i = 17; (i < ratio_log.size()) && (i <= 32); i++) begin
                expect_eq("forward_move", "decel ratio", duties[32 - i], ratio_log[i]);
            end
        end
        finish_test("forward_move", e0);
    endtask

    // Shorter way is backwards through zero
    task automatic wrap_move_check();
        int e0;
        e0 = errors;
        request_move(12'd10, 12'd4090);
        watch_move("wrap_move", 0, 3000);
        expect_eq("wrap_move", "direction", 0, pwm_cmd.direction);
        expect_eq("wrap_move", "angle_done pulses", 1, done_count);
        finish_test("wrap_move", e0);
    endtask

    task automatic accel_abort_check();
        int e0;
        e0 = errors;
        request_move(12'd2000, 12'd2200);
        watch_move("accel_abort", 4, 6000);  // Abort on step 3
        abort_angle = 1'b0;
        expect_eq("accel_abort", "angle_done pulses", 1, done_count);
        expect_eq("accel_abort", "ratio count", 7, ratio_log.size());
        foreach (ratio_log[i]) begin
            assert (ratio_log[i] != cfg.cruise_power) else begin
                $display("test accel_abort: cruise power appeared after abort");
                errors++;
            end
            // Steps 0..3 on the way up, then 2..0 on the way down
            if (i < 4) expect_eq("accel_abort", "accel ratio", duties[i], ratio_log[i]);
            else if (i < 7) expect_eq("accel_abort", "decel ratio", duties[6 - i], ratio_log[i]);
        end
        finish_test("accel_abort", e0);
    endtask

    task automatic calc_abort_check();
        int e0;
        e0 = errors;
        abort_angle = 1'b1;
        request_move(12'd500, 12'd700);
        for (int n = 0; n < 20; n++) begin
            @(negedge clock);
            expect_eq("calc_abort", "update", 0, pwm_cmd.update);
            expect_eq("calc_abort", "angle_done", 0, angle_done);
        end
        expect_eq("calc_abort", "state", int'(IDLE), int'(u_angle_to_pwm.state));
        abort_angle = 1'b0;
        finish_test("calc_abort", e0);
    endtask

    initial begin
        duty_t raw;
        duty_t duty;
        duty_t cruise;
        target_angle = '0;
        load_angle   = '0;
        load_en      = 1'b0;
        angle_update = 1'b0;
        abort_angle  = 1'b0;
        pwm_profile  = '0;
        cfg.delay_target   = 8'd0;    // Every acknowledgement is a step
        cfg.profile_offset = 8'd180;  // Large entries wrap past 255
        cfg.cruise_power   = 8'd0;
        void'($urandom(32'h2f3c));
        // Nonzero duties with distinct neighbours so every step shows as a change
        for (int i = 0; i < PROFILE_STEPS; i++) begin
            do begin
                raw  = duty_t'($urandom);
                duty = raw + cfg.profile_offset;
            end while ((duty == 0) || ((i > 0) && (duty == duties[i - 1])));
            pwm_profile[i] = raw;
            duties[i]      = duty;
        end
        do begin
            cruise = duty_t'($urandom);
        end while ((cruise == 0) || in_profile(cruise));
        cfg.cruise_power = cruise;
        // Release seen on a rising edge, first test starts on the next falling edge
        for (int n = 0; (n < 20) && (reset_n !== 1'b1); n++) begin
            @(posedge clock);
        end
        assert (reset_n === 1'b1) else begin
            $display("reset was never released");
            errors++;
        end
        @(negedge clock);
        small_move_check();
        forward_move_check();
        wrap_move_check();
        accel_abort_check();
        calc_abort_check();
        $display("tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
verilog/angle_pkg.sv
verilog/angle_delta.sv
verilog/step_pacer.sv
verilog/motion_fsm.sv
verilog/duty_select.sv
verilog/angle_to_pwm.sv
test/tb_clock_gen.sv
test/pwm_responder.sv
test/tb_angle_to_pwm.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator and run; pass only if the pass message is printed
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f list.f --top-module tb_angle_to_pwm -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -qF '*** PASSED ***' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
